//--- verilog/backend_pkg.sv
`default_nettype none

package backend_pkg;

	localparam int XLEN        = 32;
	localparam int ARCH_REGS   = 8;
	localparam int RP          = 4;
	localparam int ROB_DEPTH   = 8;
	localparam int ISSUE_DEPTH = 4;

	// Index widths derived from the sizes above
	localparam int ARCH_W = $clog2(ARCH_REGS);
	localparam int COPY_W = $clog2(RP);
	localparam int IMM_W  = 12;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4
	} alu_op_t;

	// Physical register name: which architectural register, which copy of it
	typedef struct packed {
		logic [ARCH_W-1:0] arch;
		logic [COPY_W-1:0] copy;
	} phy_tag_t;

	typedef struct packed {
		alu_op_t           op;
		logic [ARCH_W-1:0] rd;
		logic [ARCH_W-1:0] rs1;
		logic [ARCH_W-1:0] rs2;
		logic              use_imm;
		logic [IMM_W-1:0]  imm;
	} micro_op_t;

	typedef struct packed {
		alu_op_t         op;
		phy_tag_t        rd;
		phy_tag_t        rs1;
		phy_tag_t        rs2;
		logic            use_imm;
		logic [XLEN-1:0] imm;
	} alu_issue_t;

	typedef struct packed {
		phy_tag_t rd;
	} rob_entry_t;

	typedef struct packed {
		alu_op_t         op;
		phy_tag_t        rd;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
	} exe_param_t;

	typedef struct packed {
		phy_tag_t        rd;
		logic [XLEN-1:0] value;
	} wb_t;

	typedef struct packed {
		logic [ARCH_W-1:0] rd;
		logic [XLEN-1:0]   value;
	} commit_t;

endpackage

`default_nettype wire

//--- verilog/gen_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module gen_fifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 4
) (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_push,
	input  T     i_data,
	output logic o_full,
	input  logic i_pop,
	output T     o_data,
	output logic o_empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	T              mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	assign o_full  = (count == CW'(DEPTH));
	assign o_empty = (count == '0);
	assign o_data  = mem[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (i_push) begin
			mem[wr_ptr] <= i_data;
		end
	end

	// Pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
			end
			if (i_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
			end
			case ({i_push, i_pop})
				2'b10:   count <= count + CW'(1);
				2'b01:   count <= count - CW'(1);
				default: count <= count;
			endcase
		end
	end

	a_push_full: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_push |-> !o_full);
	a_pop_empty: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- verilog/dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module dispatch #(
	parameter int RP = backend_pkg::RP
) (
	input  logic                    i_op_valid,
	input  backend_pkg::micro_op_t  i_op,
	output logic                    o_op_ready,
	input  logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::COPY_W-1:0] i_rn_act,
	input  logic [backend_pkg::ARCH_REGS-1:0][RP-1:0]                  i_rn_used,
	output logic                    o_rename_valid,
	output backend_pkg::phy_tag_t   o_rename_tag,
	input  logic                    i_rob_full,
	output logic                    o_rob_push,
	output backend_pkg::rob_entry_t o_rob_entry,
	input  logic                    i_issue_full,
	output logic                    o_issue_push,
	output backend_pkg::alu_issue_t o_issue_entry
);

	localparam int CW = backend_pkg::COPY_W;

	logic [CW-1:0] rd_cur;
	logic [CW-1:0] rd_next;
	logic          next_free;
	logic          accept;

	// Copies of rd are handed out round robin
	assign rd_cur    = i_rn_act[i_op.rd];
	assign rd_next   = (rd_cur == CW'(RP - 1)) ? '0 : rd_cur + CW'(1);
	assign next_free = ~i_rn_used[i_op.rd][rd_next];

	assign o_op_ready = next_free & ~i_rob_full & ~i_issue_full;
	assign accept     = i_op_valid & o_op_ready;

	assign o_rename_valid    = accept;
	assign o_rename_tag.arch = i_op.rd;
	assign o_rename_tag.copy = rd_next;

	assign o_rob_push     = accept;
	assign o_rob_entry.rd = o_rename_tag;

	// Sources see the copies active before this rename
	assign o_issue_push           = accept;
	assign o_issue_entry.op       = i_op.op;
	assign o_issue_entry.rd       = o_rename_tag;
	assign o_issue_entry.rs1.arch = i_op.rs1;
	assign o_issue_entry.rs1.copy = i_rn_act[i_op.rs1];
	assign o_issue_entry.rs2.arch = i_op.rs2;
	assign o_issue_entry.rs2.copy = i_rn_act[i_op.rs2];
	assign o_issue_entry.use_imm  = i_op.use_imm;
	assign o_issue_entry.imm      = {
		{(backend_pkg::XLEN - backend_pkg::IMM_W){i_op.imm[backend_pkg::IMM_W-1]}},
		i_op.imm
	};

endmodule

`default_nettype wire

//--- verilog/alu_issue.sv
`timescale 1ns/1ns
`default_nettype none

module alu_issue #(
	parameter int RP = backend_pkg::RP
) (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  backend_pkg::alu_issue_t i_head,
	input  logic                    i_empty,
	output logic                    o_pop,
	input  logic [backend_pkg::ARCH_REGS-1:0][RP-1:0]                         i_wb_log,
	input  logic [backend_pkg::ARCH_REGS-1:0][RP-1:0][backend_pkg::XLEN-1:0] i_regfile,
	output logic                    o_exe_valid,
	output backend_pkg::exe_param_t o_exe
);

	logic                         rs1_ready;
	logic                         rs2_ready;
	logic [backend_pkg::XLEN-1:0] op_a;
	logic [backend_pkg::XLEN-1:0] op_b;

	assign rs1_ready = i_wb_log[i_head.rs1.arch][i_head.rs1.copy];
	// Immediate form does not wait on rs2
	assign rs2_ready = i_head.use_imm | i_wb_log[i_head.rs2.arch][i_head.rs2.copy];
	assign o_pop     = ~i_empty & rs1_ready & rs2_ready;

	assign op_a = i_regfile[i_head.rs1.arch][i_head.rs1.copy];
	assign op_b = i_head.use_imm ? i_head.imm : i_regfile[i_head.rs2.arch][i_head.rs2.copy];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_exe_valid <= 1'b0;
		end else begin
			o_exe_valid <= o_pop;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_pop) begin
			o_exe.op   <= i_head.op;
			o_exe.rd   <= i_head.rd;
			o_exe.op_a <= op_a;
			o_exe.op_b <= op_b;
		end
	end

endmodule

`default_nettype wire

//--- verilog/alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic                    i_exe_valid,
	input  backend_pkg::exe_param_t i_exe,
	output logic                    o_wb_valid,
	output backend_pkg::wb_t        o_wb
);

	logic [backend_pkg::XLEN-1:0] result;

	always_comb begin
		case (i_exe.op)
			backend_pkg::ALU_ADD: result = i_exe.op_a + i_exe.op_b;
			backend_pkg::ALU_SUB: result = i_exe.op_a - i_exe.op_b;
			backend_pkg::ALU_AND: result = i_exe.op_a & i_exe.op_b;
			backend_pkg::ALU_OR:  result = i_exe.op_a | i_exe.op_b;
			backend_pkg::ALU_XOR: result = i_exe.op_a ^ i_exe.op_b;
			default:              result = '0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= i_exe_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_exe_valid) begin
			o_wb.rd    <= i_exe.rd;
			o_wb.value <= result;
		end
	end

endmodule

`default_nettype wire

//--- verilog/phy_register.sv
`timescale 1ns/1ns
`default_nettype none

module phy_register #(
	parameter int RP = backend_pkg::RP
) (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic                  i_rename_valid,
	input  backend_pkg::phy_tag_t i_rename_tag,
	input  logic                  i_wb_valid,
	input  backend_pkg::wb_t      i_wb,
	input  logic                  i_commit_valid,
	input  backend_pkg::phy_tag_t i_commit_tag,
	output logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::COPY_W-1:0]        o_rn_act,
	output logic [backend_pkg::ARCH_REGS-1:0][RP-1:0]                         o_rn_used,
	output logic [backend_pkg::ARCH_REGS-1:0][RP-1:0]                         o_wb_log,
	output logic [backend_pkg::ARCH_REGS-1:0][RP-1:0][backend_pkg::XLEN-1:0] o_regfile
);

	// Copy each architectural register currently stands in
	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::COPY_W-1:0] archi;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_rn_act  <= '0;
			archi     <= '0;
			o_regfile <= '0;
			for (int r = 0; r < backend_pkg::ARCH_REGS; r++) begin
				o_rn_used[r] <= RP'(1);
				o_wb_log[r]  <= RP'(1);
			end
		end else begin
			// New copy is live but not yet written
			if (i_rename_valid) begin
				o_rn_act[i_rename_tag.arch]                     <= i_rename_tag.copy;
				o_rn_used[i_rename_tag.arch][i_rename_tag.copy] <= 1'b1;
				o_wb_log[i_rename_tag.arch][i_rename_tag.copy]  <= 1'b0;
			end
			if (i_wb_valid) begin
				o_regfile[i_wb.rd.arch][i_wb.rd.copy] <= i_wb.value;
				o_wb_log[i_wb.rd.arch][i_wb.rd.copy]  <= 1'b1;
			end
			// Retiring releases the copy that was architectural before
			if (i_commit_valid) begin
				o_rn_used[i_commit_tag.arch][archi[i_commit_tag.arch]] <= 1'b0;
				archi[i_commit_tag.arch]                             <= i_commit_tag.copy;
			end
		end
	end

	a_rename_free: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_rename_valid |-> !o_rn_used[i_rename_tag.arch][i_rename_tag.copy]);
	a_wb_used: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_wb_valid |-> o_rn_used[i_wb.rd.arch][i_wb.rd.copy]);

endmodule

`default_nettype wire

//--- verilog/commit.sv
`timescale 1ns/1ns
`default_nettype none

module commit #(
	parameter int RP = backend_pkg::RP
) (
	input  backend_pkg::rob_entry_t i_head,
	input  logic                    i_empty,
	output logic                    o_pop,
	input  logic [backend_pkg::ARCH_REGS-1:0][RP-1:0]                         i_wb_log,
	input  logic [backend_pkg::ARCH_REGS-1:0][RP-1:0][backend_pkg::XLEN-1:0] i_regfile,
	output logic                    o_commit_valid,
	output backend_pkg::commit_t    o_commit,
	input  logic                    i_commit_ready,
	output logic                    o_commit_tag_valid,
	output backend_pkg::phy_tag_t   o_commit_tag
);

	logic fire;

	// Head waits until its result is in the register file
	assign o_commit_valid = ~i_empty & i_wb_log[i_head.rd.arch][i_head.rd.copy];
	assign o_commit.rd    = i_head.rd.arch;
	assign o_commit.value = i_regfile[i_head.rd.arch][i_head.rd.copy];

	assign fire               = o_commit_valid & i_commit_ready;
	assign o_pop              = fire;
	assign o_commit_tag_valid = fire;
	assign o_commit_tag       = i_head.rd;

endmodule

`default_nettype wire

//--- verilog/backend_top.sv
`timescale 1ns/1ns
`default_nettype none

module backend_top #(
	parameter int RP          = backend_pkg::RP,
	parameter int ROB_DEPTH   = backend_pkg::ROB_DEPTH,
	parameter int ISSUE_DEPTH = backend_pkg::ISSUE_DEPTH
) (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_op_valid,
	input  backend_pkg::micro_op_t i_op,
	output logic                   o_op_ready,
	output logic                   o_commit_valid,
	output backend_pkg::commit_t   o_commit,
	input  logic                   i_commit_ready
);

	// Rename state from the register file
	logic [backend_pkg::ARCH_REGS-1:0][backend_pkg::COPY_W-1:0]   rn_act;
	logic [backend_pkg::ARCH_REGS-1:0][RP-1:0]                    rn_used;
	logic [backend_pkg::ARCH_REGS-1:0][RP-1:0]                    wb_log;
	logic [backend_pkg::ARCH_REGS-1:0][RP-1:0][backend_pkg::XLEN-1:0] regfile;

	logic                    rename_valid;
	backend_pkg::phy_tag_t   rename_tag;

	logic                    rob_push;
	logic                    rob_pop;
	logic                    rob_full;
	logic                    rob_empty;
	backend_pkg::rob_entry_t rob_in;
	backend_pkg::rob_entry_t rob_head;

	logic                    issue_push;
	logic                    issue_pop;
	logic                    issue_full;
	logic                    issue_empty;
	backend_pkg::alu_issue_t issue_in;
	backend_pkg::alu_issue_t issue_head;

	logic                    exe_valid;
	backend_pkg::exe_param_t exe;
	logic                    wb_valid;
	backend_pkg::wb_t        wb;

	logic                    commit_tag_valid;
	backend_pkg::phy_tag_t   commit_tag;

	dispatch #(.RP(RP)) dispatch0 (
		.i_op_valid    (i_op_valid),
		.i_op          (i_op),
		.o_op_ready    (o_op_ready),
		.i_rn_act      (rn_act),
		.i_rn_used     (rn_used),
		.o_rename_valid(rename_valid),
		.o_rename_tag  (rename_tag),
		.i_rob_full    (rob_full),
		.o_rob_push    (rob_push),
		.o_rob_entry   (rob_in),
		.i_issue_full  (issue_full),
		.o_issue_push  (issue_push),
		.o_issue_entry (issue_in)
	);

	gen_fifo #(.T(backend_pkg::rob_entry_t), .DEPTH(ROB_DEPTH)) rob_fifo (
		.i_clk   (i_clk),
		.i_arst_n(i_arst_n),
		.i_push  (rob_push),
		.i_data  (rob_in),
		.o_full  (rob_full),
		.i_pop   (rob_pop),
		.o_data  (rob_head),
		.o_empty (rob_empty)
	);

	gen_fifo #(.T(backend_pkg::alu_issue_t), .DEPTH(ISSUE_DEPTH)) issue_fifo (
		.i_clk   (i_clk),
		.i_arst_n(i_arst_n),
		.i_push  (issue_push),
		.i_data  (issue_in),
		.o_full  (issue_full),
		.i_pop   (issue_pop),
		.o_data  (issue_head),
		.o_empty (issue_empty)
	);

	alu_issue #(.RP(RP)) alu_issue0 (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_head     (issue_head),
		.i_empty    (issue_empty),
		.o_pop      (issue_pop),
		.i_wb_log   (wb_log),
		.i_regfile  (regfile),
		.o_exe_valid(exe_valid),
		.o_exe      (exe)
	);

	alu_exec alu_exec0 (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_exe_valid(exe_valid),
		.i_exe      (exe),
		.o_wb_valid (wb_valid),
		.o_wb       (wb)
	);

	phy_register #(.RP(RP)) phy_register0 (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_rename_valid(rename_valid),
		.i_rename_tag  (rename_tag),
		.i_wb_valid    (wb_valid),
		.i_wb          (wb),
		.i_commit_valid(commit_tag_valid),
		.i_commit_tag  (commit_tag),
		.o_rn_act      (rn_act),
		.o_rn_used     (rn_used),
		.o_wb_log      (wb_log),
		.o_regfile     (regfile)
	);

	commit #(.RP(RP)) commit0 (
		.i_head            (rob_head),
		.i_empty           (rob_empty),
		.o_pop             (rob_pop),
		.i_wb_log          (wb_log),
		.i_regfile         (regfile),
		.o_commit_valid    (o_commit_valid),
		.o_commit          (o_commit),
		.i_commit_ready    (i_commit_ready),
		.o_commit_tag_valid(commit_tag_valid),
		.o_commit_tag      (commit_tag)
	);

endmodule

`default_nettype wire

//--- verification/backend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module backend_tb;

	localparam int N_OPS          = 200;
	localparam int TIMEOUT_CYCLES = N_OPS * 40;
	localparam int RP             = backend_pkg::RP;

	// Commit ready modes
	localparam int MODE_OPEN   = 0;
	localparam int MODE_HOLD   = 1;
	localparam int MODE_RANDOM = 2;

	logic                   i_clk;
	logic                   i_arst_n;
	logic                   i_op_valid;
	backend_pkg::micro_op_t i_op;
	logic                   o_op_ready;
	logic                   o_commit_valid;
	backend_pkg::commit_t   o_commit;
	logic                   i_commit_ready;

	logic [15:0]            lfsr_state;
	logic [31:0]            model_regs [backend_pkg::ARCH_REGS];
	backend_pkg::commit_t   exp_q[$];
	string                  name_q[$];
	string                  test_name;
	int                     ready_mode;
	int                     accepted;
	int                     committed;
	int                     sent;
	int                     cycles;
	logic                   saw_stall;

	backend_top #(.RP(RP)) dut0 (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_op_valid    (i_op_valid),
		.i_op          (i_op),
		.o_op_ready    (o_op_ready),
		.o_commit_valid(o_commit_valid),
		.o_commit      (o_commit),
		.i_commit_ready(i_commit_ready)
	);

	always #20 i_clk = ~i_clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at the first error");
	endtask

	// Galois LFSR with taps 16, 14, 13, 11
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	// Mostly r1..r3 so that chains form
	function automatic logic [2:0] pick_reg();
		logic [1:0] p;
		p = 2'(rand_bits(2));
		if (p == 2'd3) begin
			return 3'(rand_bits(3));
		end
		return 3'(p) + 3'd1;
	endfunction

	function automatic logic [31:0] alu_model(input backend_pkg::alu_op_t op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			backend_pkg::ALU_ADD: return a + b;
			backend_pkg::ALU_SUB: return a - b;
			backend_pkg::ALU_AND: return a & b;
			backend_pkg::ALU_OR:  return a | b;
			default:              return a ^ b;
		endcase
	endfunction

	function automatic backend_pkg::micro_op_t make_op(input backend_pkg::alu_op_t op,
		input int rd, input int rs1, input int rs2, input logic use_imm, input logic [11:0] imm);
		backend_pkg::micro_op_t m;
		m.op      = op;
		m.rd      = 3'(rd);
		m.rs1     = 3'(rs1);
		m.rs2     = 3'(rs2);
		m.use_imm = use_imm;
		m.imm     = imm;
		return m;
	endfunction

	// Advance one clock and pick commit ready for the next cycle
	task automatic tick();
		@(posedge i_clk);
		if (ready_mode == MODE_HOLD && i_op_valid && !o_op_ready) begin
			saw_stall  = 1'b1;
			ready_mode = MODE_OPEN;
		end
		case (ready_mode)
			MODE_HOLD:   i_commit_ready <= 1'b0;
			MODE_RANDOM: i_commit_ready <= (rand_bits(4) >= 32'd5);
			default:     i_commit_ready <= 1'b1;
		endcase
	endtask

	task automatic send_op(input backend_pkg::micro_op_t op);
		i_op_valid <= 1'b1;
		i_op       <= op;
		tick();
		while (!o_op_ready) begin
			tick();
		end
		sent++;
	endtask

	task automatic idle(input int n);
		i_op_valid <= 1'b0;
		repeat (n) tick();
	endtask

	// Reference model and commit checks
	always @(posedge i_clk) begin : monitor
		logic [31:0]          a;
		logic [31:0]          b;
		logic [31:0]          r;
		backend_pkg::commit_t exp;
		string                name;
		if (!i_arst_n || accepted == 0) begin
			assert (o_commit_valid === 1'b0)
				else fail_run("o_commit_valid was high before any operation was accepted");
		end
		if (i_arst_n && i_op_valid && o_op_ready) begin
			a = model_regs[i_op.rs1];
			b = i_op.use_imm ? {{20{i_op.imm[11]}}, i_op.imm} : model_regs[i_op.rs2];
			r = alu_model(i_op.op, a, b);
			model_regs[i_op.rd] = r;
			exp.rd    = i_op.rd;
			exp.value = r;
			exp_q.push_back(exp);
			name_q.push_back(test_name);
			accepted++;
		end
		if (i_arst_n && o_commit_valid && i_commit_ready) begin
			assert (exp_q.size() > 0)
				else fail_run("Commit transfer with no accepted operation outstanding");
			exp  = exp_q.pop_front();
			name = name_q.pop_front();
			assert (o_commit === exp)
				else fail_run($sformatf(
					"Mismatch in %s: expected rd %0d value %h, actual rd %0d value %h",
					name, exp.rd, exp.value, o_commit.rd, o_commit.value));
			committed++;
		end
	end

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("Timeout after %0d cycles, %0d of %0d operations committed",
				cycles, committed, accepted));
		end
	end

	a_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		(o_commit_valid && !i_commit_ready) |=> (o_commit_valid && $stable(o_commit)))
		else fail_run("Commit output changed while it was waiting for i_commit_ready");

	initial begin
		i_clk          = 1'b0;
		i_arst_n       = 1'b1;
		i_op_valid     = 1'b0;
		i_op           = '0;
		i_commit_ready = 1'b1;
		lfsr_state     = 16'd14;
		ready_mode     = MODE_OPEN;
		accepted       = 0;
		committed      = 0;
		sent           = 0;
		cycles         = 0;
		saw_stall      = 1'b0;
		test_name      = "reset";
		for (int r = 0; r < backend_pkg::ARCH_REGS; r++) begin
			model_regs[r] = '0;
		end

		// Falling edge well before the first clock edge
		#1 i_arst_n = 1'b0;
		repeat (8) @(posedge i_clk);
		i_arst_n <= 1'b1;
		tick();
		assert (o_op_ready === 1'b1) else fail_run("o_op_ready was low after reset");
		idle(2);

		// Load registers through immediates, then combine them
		test_name = "immediates";
		send_op(make_op(backend_pkg::ALU_AND, 1, 1, 0, 1'b1, 12'h000));
		send_op(make_op(backend_pkg::ALU_OR,  1, 1, 0, 1'b1, 12'h5a5));
		send_op(make_op(backend_pkg::ALU_AND, 2, 2, 0, 1'b1, 12'h000));
		send_op(make_op(backend_pkg::ALU_ADD, 2, 2, 0, 1'b1, 12'h800));
		send_op(make_op(backend_pkg::ALU_SUB, 3, 1, 2, 1'b0, 12'h000));
		send_op(make_op(backend_pkg::ALU_XOR, 4, 3, 1, 1'b0, 12'h000));
		send_op(make_op(backend_pkg::ALU_OR,  6, 4, 2, 1'b0, 12'h000));
		send_op(make_op(backend_pkg::ALU_AND, 7, 6, 3, 1'b0, 12'h000));
		send_op(make_op(backend_pkg::ALU_ADD, 0, 7, 1, 1'b0, 12'h000));
		send_op(make_op(backend_pkg::ALU_SUB, 1, 0, 0, 1'b1, 12'h001));
		idle(12);

		// More writes to r5 than it has copies while commit is held
		test_name  = "rename_pressure";
		ready_mode = MODE_HOLD;
		i_commit_ready <= 1'b0;
		for (int k = 0; k < RP + 2; k++) begin
			send_op(make_op(backend_pkg::ALU_ADD, 5, 5, 0, 1'b1, 12'h011));
		end
		assert (saw_stall) else fail_run("o_op_ready did not drop under rename pressure");
		ready_mode = MODE_OPEN;
		idle(4);

		test_name  = "random";
		ready_mode = MODE_RANDOM;
		while (sent < N_OPS) begin : random_ops
			logic [2:0] k;
			k = 3'(rand_bits(3) % 5);
			send_op(make_op(backend_pkg::alu_op_t'(k), pick_reg(), pick_reg(), pick_reg(),
				rand_bits(1) != 0, 12'(rand_bits(12))));
			if (rand_bits(2) == 0) begin
				idle(1 + rand_bits(2));
			end
		end

		idle(1);
		ready_mode = MODE_OPEN;
		while (committed < accepted) begin
			tick();
		end
		// Any commit beyond the accepted operations shows up here
		idle(4);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
verilog/backend_pkg.sv
verilog/gen_fifo.sv
verilog/dispatch.sv
verilog/alu_issue.sv
verilog/alu_exec.sv
verilog/phy_register.sv
verilog/commit.sv
verilog/backend_top.sv
verification/backend_tb.sv
